/* Bender.yml */
package:
  name: wvb_readout

sources:
  - logic/wvb_data_pkg.sv
  - logic/wvb_fmt_pkg.sv
  - logic/wvb_buffer.sv
  - logic/wvb_rd_ctrl_fmt_0.sv
  - logic/wvb_readout_dpram.sv
  - logic/wvb_reader.sv
  - logic/wvb_readout_top.sv
  - target: test
    files:
      - testbench/wvb_readout_props.sv
      - testbench/tb_wvb_readout.sv

/* list.f */
logic/wvb_data_pkg.sv
logic/wvb_fmt_pkg.sv
logic/wvb_buffer.sv
logic/wvb_rd_ctrl_fmt_0.sv
logic/wvb_readout_dpram.sv
logic/wvb_reader.sv
logic/wvb_readout_top.sv
testbench/wvb_readout_props.sv
testbench/tb_wvb_readout.sv

/* logic/wvb_buffer.sv */
/*
  waveform buffer
  circular sample memory written by acquisition, with a four entry
  header queue filled as events close; the read side is show-ahead
  and its pointer follows the head of the header queue
*/
`timescale 1ns/100ps
`default_nettype none

module wvb_buffer #(
  parameter int p_wvb_adr_width = 12
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       acq_valid,
  input  logic                       acq_sof,
  input  wvb_data_pkg::wvb_sample_t  acq_sample,
  input  logic [47:0]                ltc,
  input  logic                       odd_ltc,
  input  logic [1:0]                 trig_src,
  input  logic                       cnst_run,
  input  logic                       sync_rdy,
  input  logic [4:0]                 pre_conf,
  input  logic                       rdreq,
  input  logic                       rddone,
  output wvb_data_pkg::wvb_sample_t  rd_sample,
  output wvb_data_pkg::wvb_hdr_t     hdr,
  output logic                       hdr_avail
);

  localparam int depth = 2 ** p_wvb_adr_width;

  wvb_data_pkg::wvb_sample_t mem [depth];
  wvb_data_pkg::wvb_hdr_t hq [4];
  // trigger context captured at sof
  wvb_data_pkg::wvb_hdr_t ctx;
  // context that goes with the sample being written
  wvb_data_pkg::wvb_hdr_t cur;

  logic [p_wvb_adr_width-1:0] wr_ptr;
  logic [p_wvb_adr_width-1:0] rd_ptr;
  logic [1:0] hq_wp;
  logic [1:0] hq_rp;
  logic [2:0] hq_cnt;
  logic wr_ok;
  logic push;
  logic pop;

  // samples are dropped while the header queue is full
  assign wr_ok = acq_valid && (hq_cnt != 3'd4);
  assign push = wr_ok && acq_sample.eoe;
  assign pop = rddone && hdr_avail;

  assign hdr_avail = (hq_cnt != 3'd0);
  assign hdr = hq[hq_rp];
  // show-ahead read
  assign rd_sample = mem[rd_ptr];

  // a one sample event takes its context straight from the inputs
  always_comb begin
    cur = ctx;
    if (acq_sof) begin
      cur.ltc = ltc;
      cur.odd_ltc = odd_ltc;
      cur.start_addr = wr_ptr;
      cur.trig_src = trig_src;
      cur.cnst_run = cnst_run;
      cur.pre_conf = pre_conf;
      cur.sync_rdy = sync_rdy;
    end
    cur.stop_addr = wr_ptr;
  end

  always_ff @(posedge clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= acq_sample;
    end
    if (wr_ok && acq_sof) begin
      ctx <= cur;
    end
    if (push) begin
      hq[hq_wp] <= cur;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      hq_wp <= '0;
      hq_rp <= '0;
      hq_cnt <= '0;
    end else begin
      if (wr_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (push) begin
        hq_wp <= hq_wp + 1'b1;
      end
      if (pop) begin
        hq_rp <= hq_rp + 1'b1;
      end
      case ({push, pop})
        2'b10: hq_cnt <= hq_cnt + 3'd1;
        2'b01: hq_cnt <= hq_cnt - 3'd1;
        default: hq_cnt <= hq_cnt;
      endcase

      // read pointer reloads from the new head, else steps on rdreq
      if (pop) begin
        if (hq_cnt > 3'd1) begin
          rd_ptr <= hq[hq_rp + 2'd1].start_addr;
        end else if (push) begin
          rd_ptr <= cur.start_addr;
        end
      end else if (push && (hq_cnt == 3'd0)) begin
        rd_ptr <= cur.start_addr;
      end else if (rdreq) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/wvb_data_pkg.sv */
/*
  waveform buffer data types
  one acquired sample as stored in the circular buffer, and the
  header bundle queued for each closed event
*/
`default_nettype none

package wvb_data_pkg;

  // field widths of the acquisition data
  localparam int adc_w = 12;
  localparam int disc_w = 8;
  localparam int ltc_w = 48;
  localparam int hdr_adr_w = 12;
  localparam int pre_conf_w = 5;

  // one sample word as written by acquisition
  typedef struct packed {
    logic [disc_w-1:0] discr;
    logic [adc_w-1:0]  adc;
    // time over threshold
    logic              tot;
    // last sample of the event
    logic              eoe;
  } wvb_sample_t;

  // event header bundle
  // ltc and odd_ltc together form the 120 MHz timestamp
  typedef struct packed {
    logic [ltc_w-1:0]      ltc;
    logic                  odd_ltc;
    logic [hdr_adr_w-1:0]  start_addr;
    logic [hdr_adr_w-1:0]  stop_addr;
    // sw, thresh, disc or ext
    logic [1:0]            trig_src;
    logic                  cnst_run;
    logic [pre_conf_w-1:0] pre_conf;
    logic                  sync_rdy;
  } wvb_hdr_t;

endpackage

`default_nettype wire

/* logic/wvb_fmt_pkg.sv */
/*
  format-0 readout layout
  readout DPRAM geometry, the channel word tag and the packing of
  the hdr_0 word and of one sample word
*/
`default_nettype none

package wvb_fmt_pkg;

  // readout DPRAM geometry
  localparam int dpram_aw = 10;
  localparam int dpram_dw = 32;
  localparam int dpram_depth = 1 << dpram_aw;

  // channel word tag, upper byte of the low half
  localparam logic [7:0] fmt_code = 8'h90;

  // last sample address when an event is truncated
  localparam logic [dpram_aw-1:0] dpram_a_last_data = 10'd1021;
  // last address of the DPRAM
  localparam logic [dpram_aw-1:0] dpram_a_last = 10'd1023;

  // hdr_0 word, from the top
  // pre_conf, cnst_run, six zeros, sync_rdy, odd_ltc, trig_src
  function automatic logic [15:0] hdr_0_word(input wvb_data_pkg::wvb_hdr_t h);
    return {h.pre_conf, h.cnst_run, 6'b0, h.sync_rdy, h.odd_ltc, h.trig_src};
  endfunction

  // sample word
  // high half holds disc byte, zeros, tot, eoe
  // low half holds the adc value sign extended to 16 bits
  function automatic logic [dpram_dw-1:0] sample_word(
    input wvb_data_pkg::wvb_sample_t s
  );
    logic [15:0] adc_ext;
    adc_ext = {{(16 - wvb_data_pkg::adc_w){s.adc[wvb_data_pkg::adc_w-1]}}, s.adc};
    return {s.discr, 6'b0, s.tot, s.eoe, adc_ext};
  endfunction

endpackage

`default_nettype wire

/* logic/wvb_rd_ctrl_fmt_0.sv */
/*
  format-0 read controller
  packs one event into the readout DPRAM: channel word, hdr_0 and LTC
  words, one word per sample and a footer
  mode 0 truncates at the end of the DPRAM, mode 1 continues the event
  into further fills and signals that with more
*/
`timescale 1ns/100ps
`default_nettype none

module wvb_rd_ctrl_fmt_0 #(
  parameter int p_wvb_adr_width = 12
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  req,
  input  logic [7:0]                            idx,
  input  logic                                  dpram_mode,
  input  wvb_data_pkg::wvb_hdr_t                hdr,
  input  wvb_data_pkg::wvb_sample_t             rd_sample,
  output logic                                  ack,
  output logic                                  more,
  output logic                                  rdreq,
  output logic                                  rddone,
  output logic [wvb_fmt_pkg::dpram_aw-1:0]      dpram_a,
  output logic [wvb_fmt_pkg::dpram_dw-1:0]      dpram_data,
  output logic                                  dpram_wren,
  output logic [15:0]                           dpram_len
);

  typedef enum logic [2:0] {
    s_idle,
    s_chan_len,
    s_hdr_0_ltc_2,
    s_ltc_1_ltc_0,
    s_sample,
    s_ftr,
    s_ack,
    s_req_wait
  } state_t;

  state_t state;

  // header held for the whole event, the buffer pops it early
  wvb_data_pkg::wvb_hdr_t hdr_l;
  logic [15:0] evt_len_l;
  logic [15:0] hdr_0;
  // event length modulo the buffer depth
  logic [p_wvb_adr_width-1:0] len_mod;

  // words written in this fill, one bit wider to hold 1024
  logic [wvb_fmt_pkg::dpram_aw:0] wcnt;
  logic [wvb_fmt_pkg::dpram_aw-1:0] wa;
  // footer did not fit, next fill is footer only
  logic ftr_only;

  logic wr_go;
  logic [wvb_fmt_pkg::dpram_dw-1:0] word;

  assign len_mod = hdr.stop_addr - hdr.start_addr + 1'b1;
  assign hdr_0 = wvb_fmt_pkg::hdr_0_word(hdr_l);
  assign wa = wcnt[wvb_fmt_pkg::dpram_aw-1:0];

  // each sample state cycle consumes the shown sample
  assign rdreq = (state == s_sample);

  // word for the current state
  always_comb begin
    wr_go = 1'b1;
    word = '0;
    case (state)
      s_chan_len: word = {evt_len_l, wvb_fmt_pkg::fmt_code, idx};
      s_hdr_0_ltc_2: word = {hdr_l.ltc[47:32], hdr_0};
      s_ltc_1_ltc_0: word = {hdr_l.ltc[15:0], hdr_l.ltc[31:16]};
      s_sample: word = wvb_fmt_pkg::sample_word(rd_sample);
      s_ftr: word = {hdr_0, evt_len_l};
      default: wr_go = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (wr_go) begin
      dpram_a <= wa;
      dpram_data <= word;
    end
    if ((state == s_idle) && req) begin
      hdr_l <= hdr;
      evt_len_l <= {{(16 - p_wvb_adr_width){1'b0}}, len_mod};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= s_idle;
      ack <= 1'b0;
      more <= 1'b0;
      rddone <= 1'b0;
      dpram_wren <= 1'b0;
      dpram_len <= '0;
      wcnt <= '0;
      ftr_only <= 1'b0;
    end else begin
      dpram_wren <= wr_go;
      rddone <= 1'b0;
      if (wr_go) begin
        wcnt <= wcnt + 1'b1;
      end

      case (state)
        s_idle: begin
          if (req) begin
            wcnt <= '0;
            state <= s_chan_len;
          end
        end
        s_chan_len: state <= s_hdr_0_ltc_2;
        s_hdr_0_ltc_2: state <= s_ltc_1_ltc_0;
        s_ltc_1_ltc_0: state <= s_sample;
        s_sample: begin
          if (rd_sample.eoe) begin
            rddone <= 1'b1;
            // eoe in the last word leaves no room for the footer
            if (dpram_mode && (wa == wvb_fmt_pkg::dpram_a_last)) begin
              more <= 1'b1;
              ftr_only <= 1'b1;
              state <= s_ack;
            end else begin
              state <= s_ftr;
            end
          end else if (!dpram_mode && (wa == wvb_fmt_pkg::dpram_a_last_data)) begin
            // truncate, rest of the event is dropped
            rddone <= 1'b1;
            state <= s_ftr;
          end else if (dpram_mode && (wa == wvb_fmt_pkg::dpram_a_last)) begin
            more <= 1'b1;
            state <= s_ack;
          end
        end
        s_ftr: state <= s_ack;
        s_ack: begin
          // length in 16-bit words
          dpram_len <= {{(16 - wvb_fmt_pkg::dpram_aw - 2){1'b0}}, wcnt, 1'b0};
          if (req) begin
            ack <= 1'b1;
          end else begin
            ack <= 1'b0;
            more <= 1'b0;
            state <= more ? s_req_wait : s_idle;
          end
        end
        s_req_wait: begin
          // continuation fill restarts at address 0
          if (req) begin
            wcnt <= '0;
            if (ftr_only) begin
              ftr_only <= 1'b0;
              state <= s_ftr;
            end else begin
              state <= s_sample;
            end
          end
        end
        default: state <= s_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/wvb_reader.sv */
/*
  waveform buffer reader
  requests a fill when a header is queued, presents the fill length
  to the host and re-requests while an event continues
*/
`timescale 1ns/100ps
`default_nettype none

module wvb_reader #(
  parameter logic [7:0] p_chan_idx = 8'd0
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        hdr_avail,
  input  logic        ack,
  input  logic        more,
  input  logic [15:0] dpram_len,
  input  logic        buf_done,
  output logic        req,
  output logic [7:0]  idx,
  output logic        buf_ready,
  output logic [15:0] buf_len
);

  typedef enum logic [1:0] {
    r_idle,
    r_req,
    r_ready,
    r_drop
  } rstate_t;

  rstate_t state;
  // event continues into another fill
  logic more_l;

  assign idx = p_chan_idx;

  // fill length held for the host
  always_ff @(posedge clk) begin
    if ((state == r_req) && ack) begin
      buf_len <= dpram_len;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= r_idle;
      req <= 1'b0;
      buf_ready <= 1'b0;
      more_l <= 1'b0;
    end else begin
      case (state)
        r_idle: begin
          if (hdr_avail) begin
            req <= 1'b1;
            state <= r_req;
          end
        end
        r_req: begin
          if (ack) begin
            buf_ready <= 1'b1;
            more_l <= more;
            state <= r_ready;
          end
        end
        r_ready: begin
          // host may hold off as long as it likes
          if (buf_done) begin
            req <= 1'b0;
            buf_ready <= 1'b0;
            state <= r_drop;
          end
        end
        r_drop: begin
          // wait for the controller to release ack
          if (!ack) begin
            if (more_l) begin
              req <= 1'b1;
              state <= r_req;
            end else begin
              state <= r_idle;
            end
          end
        end
        default: state <= r_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/wvb_readout_dpram.sv */
/*
  readout DPRAM
  1024 x 32 simple dual port memory, written by the read controller
  and read by the host with one cycle of latency
*/
`timescale 1ns/100ps
`default_nettype none

module wvb_readout_dpram (
  input  logic                                clk,
  input  logic                                wren,
  input  logic [wvb_fmt_pkg::dpram_aw-1:0]    wa,
  input  logic [wvb_fmt_pkg::dpram_dw-1:0]    wdata,
  input  logic [wvb_fmt_pkg::dpram_aw-1:0]    ra,
  output logic [wvb_fmt_pkg::dpram_dw-1:0]    rdata
);

  logic [wvb_fmt_pkg::dpram_dw-1:0] mem [wvb_fmt_pkg::dpram_depth];

  always_ff @(posedge clk) begin
    if (wren) begin
      mem[wa] <= wdata;
    end
    // registered read port
    rdata <= mem[ra];
  end

endmodule

`default_nettype wire

/* logic/wvb_readout_top.sv */
/*
  digitizer channel readout path
  waveform buffer, reader, format-0 read controller and readout DPRAM
  of one channel; the host reads the DPRAM while buf_ready is high
*/
`timescale 1ns/100ps
`default_nettype none

module wvb_readout_top #(
  parameter int         p_wvb_adr_width = 12,
  parameter logic [7:0] p_chan_idx = 8'd0
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                acq_valid,
  input  logic                                acq_sof,
  input  wvb_data_pkg::wvb_sample_t           acq_sample,
  input  logic [wvb_data_pkg::ltc_w-1:0]      ltc,
  input  logic                                odd_ltc,
  input  logic [1:0]                          trig_src,
  input  logic                                cnst_run,
  input  logic                                sync_rdy,
  input  logic [4:0]                          pre_conf,
  input  logic                                dpram_mode,
  input  logic [wvb_fmt_pkg::dpram_aw-1:0]    host_a,
  input  logic                                buf_done,
  output logic [wvb_fmt_pkg::dpram_dw-1:0]    host_data,
  output logic                                buf_ready,
  output logic [15:0]                         buf_len
);

  // buffer to controller
  wvb_data_pkg::wvb_sample_t rd_sample;
  wvb_data_pkg::wvb_hdr_t hdr;
  logic hdr_avail;
  logic rdreq;
  logic rddone;

  // reader to controller
  logic req;
  logic [7:0] idx;
  logic ack;
  logic more;

  // controller to DPRAM
  logic [wvb_fmt_pkg::dpram_aw-1:0] dpram_a;
  logic [wvb_fmt_pkg::dpram_dw-1:0] dpram_data;
  logic dpram_wren;
  logic [15:0] dpram_len;

  wvb_buffer #(
    .p_wvb_adr_width(p_wvb_adr_width)
  ) i_buffer (
    .clk(clk),
    .rst(rst),
    .acq_valid(acq_valid),
    .acq_sof(acq_sof),
    .acq_sample(acq_sample),
    .ltc(ltc),
    .odd_ltc(odd_ltc),
    .trig_src(trig_src),
    .cnst_run(cnst_run),
    .sync_rdy(sync_rdy),
    .pre_conf(pre_conf),
    .rdreq(rdreq),
    .rddone(rddone),
    .rd_sample(rd_sample),
    .hdr(hdr),
    .hdr_avail(hdr_avail)
  );

  wvb_reader #(
    .p_chan_idx(p_chan_idx)
  ) i_reader (
    .clk(clk),
    .rst(rst),
    .hdr_avail(hdr_avail),
    .ack(ack),
    .more(more),
    .dpram_len(dpram_len),
    .buf_done(buf_done),
    .req(req),
    .idx(idx),
    .buf_ready(buf_ready),
    .buf_len(buf_len)
  );

  wvb_rd_ctrl_fmt_0 #(
    .p_wvb_adr_width(p_wvb_adr_width)
  ) i_rd_ctrl (
    .clk(clk),
    .rst(rst),
    .req(req),
    .idx(idx),
    .dpram_mode(dpram_mode),
    .hdr(hdr),
    .rd_sample(rd_sample),
    .ack(ack),
    .more(more),
    .rdreq(rdreq),
    .rddone(rddone),
    .dpram_a(dpram_a),
    .dpram_data(dpram_data),
    .dpram_wren(dpram_wren),
    .dpram_len(dpram_len)
  );

  wvb_readout_dpram i_dpram (
    .clk(clk),
    .wren(dpram_wren),
    .wa(dpram_a),
    .wdata(dpram_data),
    .ra(host_a),
    .rdata(host_data)
  );

endmodule

`default_nettype wire

/* testbench/tb_wvb_readout.sv */
/*
  readout path testbench
  writes events into the waveform buffer, waits for each DPRAM fill,
  reads it back through the host port and compares every word with
  a model built from the format-0 layout
*/
`timescale 1ns/100ps
`default_nettype none

module tb_wvb_readout;

  localparam int clk_period = 4;
  localparam int adr_w = 12;
  localparam int depth = 1 << adr_w;
  localparam logic [7:0] chan_idx = 8'h2c;
  // event lengths of the tests
  localparam int n_short = 20;
  localparam int n_trunc = 1100;
  localparam int n_span = 1500;
  localparam int n_edge = 1021;
  localparam int n_q0 = 30;
  localparam int n_q1 = 45;
  localparam int n_pat = 8;
  localparam int total_smp = n_short + n_trunc + n_span + n_edge + n_q0 + n_q1 + n_pat;
  // about four cycles per sample for write, fill and host read
  // plus a margin for handshakes and host delays
  localparam int limit_cycles = total_smp * 4 + 2000;

  logic clk;
  logic rst;
  logic acq_valid;
  logic acq_sof;
  wvb_data_pkg::wvb_sample_t acq_sample;
  logic [47:0] ltc;
  logic odd_ltc;
  logic [1:0] trig_src;
  logic cnst_run;
  logic sync_rdy;
  logic [4:0] pre_conf;
  logic dpram_mode;
  logic [9:0] host_a;
  logic buf_done;
  logic [31:0] host_data;
  logic buf_ready;
  logic [15:0] buf_len;

  logic [31:0] lfsr = 32'hb54d_0a87;
  int checks = 0;
  int errors = 0;
  int afails;
  // samples of the event being built
  wvb_data_pkg::wvb_sample_t evt[$];
  // written events waiting for readout
  wvb_data_pkg::wvb_sample_t smp_q[$];
  wvb_data_pkg::wvb_hdr_t ctx_q[$];
  int len_q[$];
  // expected words of one fill
  logic [31:0] exp_q[$];

  wvb_readout_top #(
    .p_wvb_adr_width(adr_w),
    .p_chan_idx(chan_idx)
  ) i_dut (
    .clk(clk),
    .rst(rst),
    .acq_valid(acq_valid),
    .acq_sof(acq_sof),
    .acq_sample(acq_sample),
    .ltc(ltc),
    .odd_ltc(odd_ltc),
    .trig_src(trig_src),
    .cnst_run(cnst_run),
    .sync_rdy(sync_rdy),
    .pre_conf(pre_conf),
    .dpram_mode(dpram_mode),
    .host_a(host_a),
    .buf_done(buf_done),
    .host_data(host_data),
    .buf_ready(buf_ready),
    .buf_len(buf_len)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(limit_cycles * clk_period);
    $display("watchdog expired after %0d cycles, readout did not complete", limit_cycles);
    $display("Test FAILED");
    $finish;
  end

  // fibonacci lfsr with taps 32 22 2 1 and one step per bit
  function automatic logic [47:0] next_bits(input int n);
    logic [47:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v = {v[46:0], lfsr[0]};
    end
    return v;
  endfunction

  // disc byte, six zeros, tot and eoe above the sign extended adc
  function automatic logic [31:0] exp_sample(input wvb_data_pkg::wvb_sample_t s);
    logic signed [15:0] adc_s;
    adc_s = $signed(s.adc);
    return {s.discr, 6'b0, s.tot, s.eoe, adc_s};
  endfunction

  function automatic wvb_data_pkg::wvb_sample_t mk_sample(input logic [7:0] discr,
      input logic [11:0] adc, input logic tot, input logic eoe);
    wvb_data_pkg::wvb_sample_t s;
    s.discr = discr;
    s.adc = adc;
    s.tot = tot;
    s.eoe = eoe;
    return s;
  endfunction

  task automatic compare(input logic [31:0] got, input logic [31:0] want, input string what);
    checks++;
    if (got !== want) begin
      errors++;
      $display("ERROR %0d ns: %s got %h expected %h", $time, what, got, want);
    end
  endtask

  // drives the samples in evt with a random trigger context
  task automatic drive_event();
    wvb_data_pkg::wvb_hdr_t c;
    c = '0;
    c.ltc = next_bits(48);
    c.odd_ltc = 1'(next_bits(1));
    c.trig_src = 2'(next_bits(2));
    c.cnst_run = 1'(next_bits(1));
    c.sync_rdy = 1'(next_bits(1));
    c.pre_conf = 5'(next_bits(5));
    ctx_q.push_back(c);
    len_q.push_back(evt.size());
    ltc = c.ltc;
    odd_ltc = c.odd_ltc;
    trig_src = c.trig_src;
    cnst_run = c.cnst_run;
    sync_rdy = c.sync_rdy;
    pre_conf = c.pre_conf;
    for (int i = 0; i < evt.size(); i++) begin
      acq_valid = 1'b1;
      acq_sof = (i == 0);
      acq_sample = evt[i];
      smp_q.push_back(evt[i]);
      @(negedge clk);
    end
    acq_valid = 1'b0;
    acq_sof = 1'b0;
  endtask

  task automatic random_event(input int n);
    wvb_data_pkg::wvb_sample_t s;
    evt.delete();
    for (int i = 0; i < n; i++) begin
      s = mk_sample(8'(next_bits(8)), 12'(next_bits(12)), 1'(next_bits(1)), i == n - 1);
      evt.push_back(s);
    end
    drive_event();
  endtask

  // wait for one fill and compare it word by word
  task automatic read_fill(input int delay);
    int a;
    while (!buf_ready) @(negedge clk);
    compare({16'h0, buf_len}, 2 * exp_q.size(), "buf_len");
    for (a = 0; a < exp_q.size(); a++) begin
      host_a = 10'(a);
      @(negedge clk);
      compare(host_data, exp_q[a], $sformatf("word %0d", a));
    end
    // host back-pressure
    repeat (delay) @(negedge clk);
    buf_done = 1'b1;
    @(negedge clk);
    buf_done = 1'b0;
  endtask

  // model of the fills for the oldest written event
  task automatic check_event(input int delay);
    wvb_data_pkg::wvb_hdr_t c;
    wvb_data_pkg::wvb_sample_t s_ev[$];
    logic [15:0] len;
    logic [15:0] hdr0;
    int n;
    int k;
    int last_a;
    bit first;
    bit ftr_left;
    c = ctx_q.pop_front();
    n = len_q.pop_front();
    repeat (n) s_ev.push_back(smp_q.pop_front());
    len = 16'(n % depth);
    hdr0 = {c.pre_conf, c.cnst_run, 6'b0, c.sync_rdy, c.odd_ltc, c.trig_src};
    last_a = dpram_mode ? int'(wvb_fmt_pkg::dpram_a_last) :
      int'(wvb_fmt_pkg::dpram_a_last_data);
    first = 1'b1;
    ftr_left = 1'b1;
    k = 0;
    while (ftr_left) begin
      exp_q.delete();
      if (first) begin
        exp_q.push_back({len, wvb_fmt_pkg::fmt_code, chan_idx});
        exp_q.push_back({c.ltc[47:32], hdr0});
        exp_q.push_back({c.ltc[15:0], c.ltc[31:16]});
        first = 1'b0;
      end
      while ((k < n) && (exp_q.size() <= last_a)) begin
        exp_q.push_back(exp_sample(s_ev[k]));
        k++;
      end
      // mode 0 drops the samples that did not fit
      if (!dpram_mode) begin
        k = n;
      end
      // the footer goes where a word is left and otherwise opens the next fill
      if ((k == n) && (exp_q.size() <= int'(wvb_fmt_pkg::dpram_a_last))) begin
        exp_q.push_back({hdr0, len});
        ftr_left = 1'b0;
      end
      read_fill(delay);
    end
  endtask

  task automatic short_event();
    dpram_mode = 1'b0;
    random_event(n_short);
    check_event(0);
  endtask

  task automatic truncated_event();
    dpram_mode = 1'b0;
    random_event(n_trunc);
    check_event(0);
  endtask

  task automatic spanning_event();
    dpram_mode = 1'b1;
    random_event(n_span);
    check_event(0);
  endtask

  task automatic footer_only_fill();
    // 3 header words + 1021 samples puts eoe at address 1023
    dpram_mode = 1'b1;
    random_event(n_edge);
    check_event(0);
  endtask

  task automatic queued_events();
    dpram_mode = 1'b0;
    random_event(n_q0);
    random_event(n_q1);
    check_event(40);
    check_event(40);
  endtask

  task automatic sample_bit_positions();
    dpram_mode = 1'b0;
    evt.delete();
    evt.push_back(mk_sample(8'ha5, 12'h800, 1'b1, 1'b0));
    evt.push_back(mk_sample(8'h5a, 12'h7ff, 1'b0, 1'b0));
    evt.push_back(mk_sample(8'hff, 12'hfff, 1'b1, 1'b0));
    evt.push_back(mk_sample(8'h00, 12'h001, 1'b0, 1'b0));
    evt.push_back(mk_sample(8'h80, 12'h801, 1'b1, 1'b0));
    evt.push_back(mk_sample(8'h3c, 12'h000, 1'b0, 1'b0));
    evt.push_back(mk_sample(8'hc3, 12'h7fe, 1'b1, 1'b0));
    evt.push_back(mk_sample(8'h01, 12'hfff, 1'b0, 1'b1));
    drive_event();
    check_event(0);
    // hand-computed words for the most negative adc and for the eoe sample
    host_a = 10'd3;
    @(negedge clk);
    compare(host_data, 32'ha502_f800, "first sample word");
    host_a = 10'd3 + 10'(n_pat - 1);
    @(negedge clk);
    compare(host_data, 32'h0101_ffff, "eoe sample word");
  endtask

  initial begin
    rst = 1'b1;
    acq_valid = 1'b0;
    acq_sof = 1'b0;
    acq_sample = '0;
    ltc = '0;
    odd_ltc = 1'b0;
    trig_src = '0;
    cnst_run = 1'b0;
    sync_rdy = 1'b0;
    pre_conf = '0;
    dpram_mode = 1'b0;
    host_a = '0;
    buf_done = 1'b0;
    repeat (4) @(negedge clk);
    rst = 1'b0;
    compare({31'h0, buf_ready}, 32'h0, "buf_ready after reset");
    short_event();
    truncated_event();
    spanning_event();
    footer_only_fill();
    queued_events();
    sample_bit_positions();
    afails = i_dut.i_rd_ctrl.i_props.fail_cnt;
    $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, afails);
    if ((errors == 0) && (afails == 0)) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/wvb_readout_props.sv */
/*
  readout controller properties
  concurrent checks on the request, acknowledge and write handshake
  of the format-0 read controller, bound into every instance
*/
`timescale 1ns/100ps
`default_nettype none

module wvb_readout_props (
  input logic clk,
  input logic rst,
  input logic req,
  input logic ack,
  input logic dpram_wren,
  input logic rddone
);

  // number of failed assertions
  int fail_cnt = 0;

  // a fill is only acknowledged for a pending request
  a_ack_req: assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> req)
    else begin
      fail_cnt++;
      $error("ack rose while req was low");
    end

  // all DPRAM writes of a fill finish before ack
  a_wren_ack: assert property (@(posedge clk) disable iff (rst) !(dpram_wren && ack))
    else begin
      fail_cnt++;
      $error("dpram_wren high while ack high");
    end

  // header pop is one cycle wide
  a_rddone_pulse: assert property (@(posedge clk) disable iff (rst) rddone |=> !rddone)
    else begin
      fail_cnt++;
      $error("rddone held for more than one cycle");
    end

endmodule

bind wvb_rd_ctrl_fmt_0 wvb_readout_props i_props (
  .clk(clk),
  .rst(rst),
  .req(req),
  .ack(ack),
  .dpram_wren(dpram_wren),
  .rddone(rddone)
);

`default_nettype wire
